// ==== design/ptw_cfg_pkg.sv ====
// address geometry of the two-level page table walker
// 8 KiB pages, 8-byte PTEs, 32-bit virtual and physical addresses
// also holds the table base register type and the table address helper

`default_nettype none

package ptw_cfg_pkg;

	parameter int VADDR_BITS = 32;
	parameter int PAGE_BITS = 13;
	// level 0 index width, level 1 takes what is left above it
	parameter int INDEX_BITS = 10;
	parameter int PTE_SHIFT = 3;

	typedef logic [VADDR_BITS-PAGE_BITS-1:0] ppn_t;
	typedef logic [7:0] asid_t;
	typedef logic level_t;
	typedef logic [VADDR_BITS-1:0] vaddr_t;

	typedef struct packed {
		ppn_t base;
		level_t level;
	} ptbr_t;

	// address of the PTE for va inside the table page at base
	function automatic vaddr_t table_addr(input ppn_t base, input level_t level,
		input vaddr_t va);
		vaddr_t index;
		if (level)
			index = vaddr_t'(va[VADDR_BITS-1:PAGE_BITS+INDEX_BITS]);
		else
			index = vaddr_t'(va[PAGE_BITS+INDEX_BITS-1:PAGE_BITS]);
		return {base, {PAGE_BITS{1'b0}}} + (index << PTE_SHIFT);
	endfunction

endpackage

`default_nettype wire

// ==== design/ptw_queue_pkg.sv ====
// miss queue and stream payload types of the page table walker
// entry layout, table read request/response, entry update, completion

`default_nettype none

package ptw_queue_pkg;

	import ptw_cfg_pkg::*;

	parameter int QUEUE_DEPTH_MAX = 16;

	typedef logic [$clog2(QUEUE_DEPTH_MAX)-1:0] qtag_t;

	typedef enum logic [1:0] {
		ST_FREE,
		ST_PENDING,
		ST_READING
	} entry_state_t;

	typedef struct packed {
		asid_t asid;
		vaddr_t vaddr;
	} miss_t;

	typedef struct packed {
		entry_state_t state;
		level_t level;
		asid_t asid;
		vaddr_t vaddr;
		vaddr_t tadr;
	} entry_t;

	typedef struct packed {
		qtag_t tag;
		vaddr_t tadr;
	} rd_req_t;

	// pte bit 0 is valid, bits 31:13 hold the page number
	typedef struct packed {
		qtag_t tag;
		logic [31:0] pte;
	} rd_rsp_t;

	typedef struct packed {
		qtag_t tag;
		logic retire;
		level_t level;
		vaddr_t tadr;
	} entry_upd_t;

	typedef struct packed {
		asid_t asid;
		vaddr_t vaddr;
		ppn_t ppn;
		logic fault;
	} done_t;

endpackage

`default_nettype wire

// ==== design/ptw_stage_reg.sv ====
// one slot valid/ready pipeline register for any payload type

`default_nettype none

module ptw_stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic in_valid,
	input wire payload_t in_data,
	output logic in_ready,
	output logic out_valid,
	output payload_t out_data,
	input wire logic out_ready
);

	logic full;

	// takes new data while empty or while the held word drains
	assign in_ready = !full || out_ready;
	assign out_valid = full;

	always_ff @(posedge clk) begin
		if (rst)
			full <= 1'b0;
		else if (in_valid && in_ready)
			full <= 1'b1;
		else if (out_ready)
			full <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			out_data <= in_data;
	end

endmodule

`default_nettype wire

// ==== design/ptw_apb_regs.sv ====
// APB configuration slave of the page table walker
// offset 0 table base page number, offset 4 root level

`default_nettype none

module ptw_apb_regs
	import ptw_cfg_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [3:0] paddr,
	input wire logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output ptbr_t ptbr
);

	// zero wait state slave that never errors
	assign pready = 1'b1;
	assign pslverr = 1'b0;

	always_ff @(posedge clk) begin
		if (rst) begin
			ptbr.base <= '0;
			ptbr.level <= 1'b0;
		end else if (psel && penable && pwrite) begin
			case (paddr)
				4'h0: ptbr.base <= pwdata[VADDR_BITS-PAGE_BITS-1:0];
				4'h4: ptbr.level <= pwdata[0];
				default: ;
			endcase
		end
	end

	// unused bits and unmapped offsets read as zero
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				4'h0: prdata = 32'(ptbr.base);
				4'h4: prdata = 32'(ptbr.level);
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/ptw_miss_queue.sv ====
// miss queue of the page table walker
// duplicate detection, lowest free slot allocation, first table address,
// issue marking and write back / retirement of walk steps

`default_nettype none

module ptw_miss_queue
	import ptw_cfg_pkg::*;
	import ptw_queue_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic miss_valid,
	input wire miss_t miss,
	input wire ptbr_t ptbr,
	input wire logic issue_valid,
	input wire qtag_t issue_tag,
	input wire logic upd_valid,
	input wire entry_upd_t upd,
	output logic miss_ready,
	output logic in_que,
	output entry_t [QUEUE_DEPTH-1:0] entries
);

	logic dup;
	logic free_found;
	qtag_t free_tag;
	logic accept;

	// ========================================================================
	// lookup
	// ========================================================================

	always_comb begin
		dup = 1'b0;
		free_found = 1'b0;
		free_tag = '0;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			if (entries[i].state != ST_FREE && entries[i].asid == miss.asid &&
				entries[i].vaddr == miss.vaddr)
				dup = 1'b1;
			if (!free_found && entries[i].state == ST_FREE) begin
				free_found = 1'b1;
				free_tag = qtag_t'(i);
			end
		end
	end

	// a duplicate is always taken, and simply dropped
	assign miss_ready = dup || free_found;
	assign accept = miss_valid && miss_ready;

	// ========================================================================
	// entry writes
	// ========================================================================

	// alloc hits a free slot, issue a pending one, update a reading one,
	// so the three writes never land on the same entry
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < QUEUE_DEPTH; i++)
				entries[i].state <= ST_FREE;
			in_que <= 1'b0;
		end else begin
			in_que <= accept && dup;
			if (accept && !dup) begin
				entries[free_tag].state <= ST_PENDING;
				entries[free_tag].level <= ptbr.level;
				entries[free_tag].asid <= miss.asid;
				entries[free_tag].vaddr <= miss.vaddr;
				entries[free_tag].tadr <= table_addr(ptbr.base, ptbr.level, miss.vaddr);
			end
			if (issue_valid)
				entries[issue_tag].state <= ST_READING;
			if (upd_valid) begin
				if (upd.retire) begin
					entries[upd.tag].state <= ST_FREE;
				end else begin
					entries[upd.tag].state <= ST_PENDING;
					entries[upd.tag].level <= upd.level;
					entries[upd.tag].tadr <= upd.tadr;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/ptw_read_issue.sv ====
// table read issue stage
// picks the lowest pending entry and loads its read into a stage register

`default_nettype none

module ptw_read_issue
	import ptw_queue_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire entry_t [QUEUE_DEPTH-1:0] entries,
	input wire logic rd_req_ready,
	output logic rd_req_valid,
	output rd_req_t rd_req,
	output logic issue_valid,
	output qtag_t issue_tag
);

	logic pick_found;
	rd_req_t pick_req;
	logic stage_ready;

	always_comb begin
		pick_found = 1'b0;
		issue_tag = '0;
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			if (!pick_found && entries[i].state == ST_PENDING) begin
				pick_found = 1'b1;
				issue_tag = qtag_t'(i);
			end
		end
		pick_req.tag = issue_tag;
		pick_req.tadr = entries[issue_tag].tadr;
	end

	// the queue marks the entry reading on the same edge the stage loads
	assign issue_valid = pick_found && stage_ready;

	ptw_stage_reg #(
		.payload_t(rd_req_t)
	) req_stage_i (
		.clk(clk),
		.rst(rst),
		.in_valid(pick_found),
		.in_data(pick_req),
		.in_ready(stage_ready),
		.out_valid(rd_req_valid),
		.out_data(rd_req),
		.out_ready(rd_req_ready)
	);

endmodule

`default_nettype wire

// ==== design/ptw_pte_update.sv ====
// PTE handling stage
// an invalid PTE or a level 0 PTE retires the entry into the completion
// register, a valid level 1 PTE sends the entry back for its level 0 read

`default_nettype none

module ptw_pte_update
	import ptw_cfg_pkg::*;
	import ptw_queue_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic rd_rsp_valid,
	input wire rd_rsp_t rd_rsp,
	input wire entry_t [QUEUE_DEPTH-1:0] entries,
	input wire logic done_ready,
	output logic rd_rsp_ready,
	output logic upd_valid,
	output entry_upd_t upd,
	output logic done_valid,
	output done_t done
);

	entry_t ent;
	logic pte_valid;
	ppn_t pte_ppn;
	logic retire;
	done_t done_next;
	logic done_in_ready;

	assign ent = entries[rd_rsp.tag];
	assign pte_valid = rd_rsp.pte[0];
	assign pte_ppn = rd_rsp.pte[VADDR_BITS-1:PAGE_BITS];
	assign retire = !pte_valid || ent.level == 1'b0;

	// ========================================================================
	// completion
	// ========================================================================

	always_comb begin
		done_next.asid = ent.asid;
		done_next.vaddr = ent.vaddr;
		done_next.ppn = pte_valid ? pte_ppn : '0;
		done_next.fault = !pte_valid;
	end

	// only a retiring response has to wait on the completion register
	assign rd_rsp_ready = !retire || done_in_ready;

	ptw_stage_reg #(
		.payload_t(done_t)
	) done_stage_i (
		.clk(clk),
		.rst(rst),
		.in_valid(rd_rsp_valid && retire),
		.in_data(done_next),
		.in_ready(done_in_ready),
		.out_valid(done_valid),
		.out_data(done),
		.out_ready(done_ready)
	);

	// ========================================================================
	// write back to the queue
	// ========================================================================

	assign upd_valid = rd_rsp_valid && rd_rsp_ready;

	always_comb begin
		upd.tag = rd_rsp.tag;
		upd.retire = retire;
		upd.level = 1'b0;
		upd.tadr = table_addr(pte_ppn, 1'b0, ent.vaddr);
	end

endmodule

`default_nettype wire

// ==== design/ptw_walk.sv ====
// top level of the two-level page table walker
// APB registers, miss queue, read issue and PTE update stages

`default_nettype none

module ptw_walk
	import ptw_cfg_pkg::*;
	import ptw_queue_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [3:0] paddr,
	input wire logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input wire logic miss_valid,
	input wire miss_t miss,
	output logic miss_ready,
	output logic in_que,
	output logic rd_req_valid,
	output rd_req_t rd_req,
	input wire logic rd_req_ready,
	input wire logic rd_rsp_valid,
	input wire rd_rsp_t rd_rsp,
	output logic rd_rsp_ready,
	output logic done_valid,
	output done_t done,
	input wire logic done_ready
);

	ptbr_t ptbr;
	entry_t [QUEUE_DEPTH-1:0] entries;
	logic issue_valid;
	qtag_t issue_tag;
	logic upd_valid;
	entry_upd_t upd;

	ptw_apb_regs regs_i (
		.clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .ptbr(ptbr)
	);

	ptw_miss_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue_i (
		.clk(clk), .rst(rst), .miss_valid(miss_valid), .miss(miss), .ptbr(ptbr),
		.issue_valid(issue_valid), .issue_tag(issue_tag), .upd_valid(upd_valid),
		.upd(upd), .miss_ready(miss_ready), .in_que(in_que), .entries(entries)
	);

	ptw_read_issue #(.QUEUE_DEPTH(QUEUE_DEPTH)) issue_i (
		.clk(clk), .rst(rst), .entries(entries), .rd_req_ready(rd_req_ready),
		.rd_req_valid(rd_req_valid), .rd_req(rd_req), .issue_valid(issue_valid),
		.issue_tag(issue_tag)
	);

	ptw_pte_update #(.QUEUE_DEPTH(QUEUE_DEPTH)) update_i (
		.clk(clk), .rst(rst), .rd_rsp_valid(rd_rsp_valid), .rd_rsp(rd_rsp),
		.entries(entries), .done_ready(done_ready), .rd_rsp_ready(rd_rsp_ready),
		.upd_valid(upd_valid), .upd(upd), .done_valid(done_valid), .done(done)
	);

endmodule

`default_nettype wire

// ==== bench/ptw_walk_assertions.sv ====
// concurrent checks bound onto the walker top level
// read request and completion hold while stalled, miss_ready after reset

`default_nettype none

module ptw_walk_assertions
	import ptw_queue_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic miss_ready,
	input wire logic rd_req_valid,
	input wire logic rd_req_ready,
	input wire rd_req_t rd_req,
	input wire logic done_valid,
	input wire logic done_ready,
	input wire done_t done
);

	timeunit 1ns;
	timeprecision 100ps;

	// read by the testbench at the end of the run
	int error_count = 0;

	req_hold_a: assert property (@(posedge clk) disable iff (rst)
		rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req))
	else begin
		error_count++;
		$error("read request changed or dropped while stalled");
	end

	done_hold_a: assert property (@(posedge clk) disable iff (rst)
		done_valid && !done_ready |=> done_valid && $stable(done))
	else begin
		error_count++;
		$error("completion changed or dropped while stalled");
	end

	// an empty queue takes any miss
	reset_ready_a: assert property (@(posedge clk) $fell(rst) |-> miss_ready)
	else begin
		error_count++;
		$error("miss_ready low right after reset");
	end

endmodule

bind ptw_walk ptw_walk_assertions walk_checks_i (.*);

`default_nettype wire

// ==== bench/tb_ptw_walk.sv ====
// testbench of the two-level page table walker
// clock and reset, APB and miss drivers, table memory model with random
// reply order and latency, directed tests on walks, duplicates, faults
// and a full queue

`default_nettype none

module tb_ptw_walk
	import ptw_cfg_pkg::*;
	import ptw_queue_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int QUEUE_DEPTH = 4;
	localparam int TIMEOUT = 500;
	localparam logic [31:0] SEED = 32'hc2d3_f448;
	localparam ppn_t TABLE_BASE = 19'h2_4c31;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [3:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic miss_valid;
	miss_t miss;
	logic miss_ready;
	logic in_que;
	logic rd_req_valid;
	rd_req_t rd_req;
	logic rd_req_ready;
	logic rd_rsp_valid;
	rd_rsp_t rd_rsp;
	logic rd_rsp_ready;
	logic done_valid;
	done_t done;
	logic done_ready;

	// memory model controls and the log of accepted read addresses
	logic mem_hold;
	logic fault_en;
	logic [31:0] fault_adr;
	logic [31:0] req_log[$];

	ptw_walk #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ========================================================================
	// reference model
	// ========================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// table contents, a hash of the whole entry address, valid bit set
	function automatic logic [31:0] table_word(input logic [31:0] adr);
		logic [31:0] h;
		h = (adr ^ 32'h6b2f_91d5) * 32'h9e37_79b1;
		h = h ^ (h >> 15);
		return {h[31:13], 12'h000, 1'b1};
	endfunction

	function automatic logic [31:0] l1_adr(input ppn_t base, input vaddr_t va);
		return {base, 13'h0000} + {20'h0_0000, va[31:23], 3'b000};
	endfunction

	function automatic logic [31:0] l0_adr(input ppn_t base, input vaddr_t va);
		return {base, 13'h0000} + {19'h0_0000, va[22:13], 3'b000};
	endfunction

	function automatic ppn_t walk_ppn(input ppn_t base, input level_t root, input vaddr_t va);
		logic [31:0] w;
		if (root) begin
			w = table_word(l1_adr(base, va));
			w = table_word(l0_adr(w[31:13], va));
		end else
			w = table_word(l0_adr(base, va));
		return w[31:13];
	endfunction

	// ========================================================================
	// checks and drivers
	// ========================================================================

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_done(input done_t d, input asid_t asid, input vaddr_t va,
		input logic fault, input ppn_t ppn);
		check_value("done.asid", 64'(d.asid), 64'(asid));
		check_value("done.vaddr", 64'(d.vaddr), 64'(va));
		check_value("done.fault", 64'(d.fault), 64'(fault));
		if (!fault)
			check_value("done.ppn", 64'(d.ppn), 64'(ppn));
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic apb_access(input logic write, input logic [3:0] adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = adr;
		pwdata = wdata;
		next_cycle();
		penable = 1'b1;
		n = 0;
		@(negedge clk);
		while (!pready) begin
			n++;
			if (n > TIMEOUT)
				stop_with_failure("timeout waiting for pready");
			@(negedge clk);
		end
		check_value("pslverr", 64'(pslverr), 64'h0);
		rdata = prdata;
		next_cycle();
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic send_miss(input asid_t asid, input vaddr_t va);
		int n;
		miss_valid = 1'b1;
		miss.asid = asid;
		miss.vaddr = va;
		n = 0;
		@(negedge clk);
		while (!miss_ready) begin
			n++;
			if (n > TIMEOUT)
				stop_with_failure("timeout waiting for miss_ready");
			@(negedge clk);
		end
		next_cycle();
		miss_valid = 1'b0;
	endtask

	task automatic wait_done(output done_t d);
		int n;
		n = 0;
		@(negedge clk);
		while (!(done_valid && done_ready)) begin
			n++;
			if (n > TIMEOUT)
				stop_with_failure("timeout waiting for a walk completion");
			@(negedge clk);
		end
		d = done;
		next_cycle();
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			if (done_valid || rd_req_valid)
				stop_with_failure("unexpected walk activity after the last completion");
		end
		next_cycle();
	endtask

	// ========================================================================
	// table memory model
	// ========================================================================

	initial begin : table_memory
		logic [31:0] rng;
		logic req_take;
		logic rsp_take;
		logic hold;
		rd_req_t req;
		qtag_t pend_tag[$];
		logic [31:0] pend_adr[$];
		int pend_wait[$];
		int start;
		int pick;
		logic [31:0] word;
		rng = SEED;
		rd_req_ready = 1'b0;
		rd_rsp_valid = 1'b0;
		rd_rsp = '0;
		forever begin
			@(negedge clk);
			req_take = rd_req_valid && rd_req_ready;
			rsp_take = rd_rsp_valid && rd_rsp_ready;
			hold = mem_hold;
			req = rd_req;
			next_cycle();
			if (req_take) begin
				rng = xorshift32(rng);
				pend_tag.push_back(req.tag);
				pend_adr.push_back(req.tadr);
				pend_wait.push_back(int'(rng % 5));
				req_log.push_back(req.tadr);
			end
			if (rsp_take)
				rd_rsp_valid = 1'b0;
			foreach (pend_wait[i])
				if (pend_wait[i] > 0)
					pend_wait[i]--;
			// reply to a random ripe read, so replies come out of order
			if (!rd_rsp_valid && !hold && pend_tag.size() > 0) begin
				rng = xorshift32(rng);
				start = int'(rng % pend_tag.size());
				pick = -1;
				for (int k = 0; k < pend_tag.size(); k++)
					if (pick < 0 && pend_wait[(start + k) % pend_tag.size()] == 0)
						pick = (start + k) % pend_tag.size();
				if (pick >= 0) begin
					word = table_word(pend_adr[pick]);
					if (fault_en && pend_adr[pick] == fault_adr)
						word[0] = 1'b0;
					rd_rsp_valid = 1'b1;
					rd_rsp.tag = pend_tag[pick];
					rd_rsp.pte = word;
					pend_tag.delete(pick);
					pend_adr.delete(pick);
					pend_wait.delete(pick);
				end
			end
			rd_req_ready = !hold;
		end
	end

	// ========================================================================
	// directed tests
	// ========================================================================

	task automatic test_apb_regs();
		logic [31:0] r;
		apb_access(1'b1, 4'h0, 32'hdead_beef, r);
		apb_access(1'b1, 4'h4, 32'hffff_fffe, r);
		apb_access(1'b0, 4'h0, 32'h0, r);
		check_value("prdata base", 64'(r), 64'(32'hdead_beef & 32'h0007_ffff));
		apb_access(1'b0, 4'h4, 32'h0, r);
		check_value("prdata level", 64'(r), 64'h0);
		apb_access(1'b1, 4'h4, 32'h8000_0003, r);
		apb_access(1'b0, 4'h4, 32'h0, r);
		check_value("prdata level", 64'(r), 64'h1);
		apb_access(1'b0, 4'h8, 32'h0, r);
		check_value("prdata unmapped", 64'(r), 64'h0);
		apb_access(1'b1, 4'h0, 32'(TABLE_BASE), r);
	endtask

	task automatic test_two_level_walk();
		done_t d;
		vaddr_t va;
		logic [31:0] w;
		va = 32'h5b7e_4a10;
		req_log.delete();
		send_miss(8'h21, va);
		wait_done(d);
		check_value("read count", 64'(req_log.size()), 64'd2);
		check_value("rd_req.tadr level 1", 64'(req_log[0]), 64'(l1_adr(TABLE_BASE, va)));
		w = table_word(l1_adr(TABLE_BASE, va));
		check_value("rd_req.tadr level 0", 64'(req_log[1]), 64'(l0_adr(w[31:13], va)));
		check_done(d, 8'h21, va, 1'b0, walk_ppn(TABLE_BASE, 1'b1, va));
	endtask

	task automatic test_duplicate_miss();
		done_t d;
		vaddr_t va;
		va = 32'h0a41_c7f8;
		req_log.delete();
		mem_hold = 1'b1;
		send_miss(8'h33, va);
		@(negedge clk);
		check_value("in_que", 64'(in_que), 64'h0);
		next_cycle();
		send_miss(8'h33, va);
		@(negedge clk);
		check_value("in_que", 64'(in_que), 64'h1);
		@(negedge clk);
		check_value("in_que", 64'(in_que), 64'h0);
		next_cycle();
		mem_hold = 1'b0;
		wait_done(d);
		check_done(d, 8'h33, va, 1'b0, walk_ppn(TABLE_BASE, 1'b1, va));
		expect_quiet(30);
		check_value("read count", 64'(req_log.size()), 64'd2);
	endtask

	task automatic test_fault_and_short_walk();
		done_t d;
		vaddr_t va;
		logic [31:0] r;
		va = 32'h9c05_6e38;
		fault_adr = l1_adr(TABLE_BASE, va);
		fault_en = 1'b1;
		req_log.delete();
		send_miss(8'h44, va);
		wait_done(d);
		check_value("read count", 64'(req_log.size()), 64'd1);
		check_done(d, 8'h44, va, 1'b1, '0);
		fault_en = 1'b0;
		// root level 0 walks straight to the leaf table
		apb_access(1'b1, 4'h4, 32'h0, r);
		va = 32'h31d2_a404;
		req_log.delete();
		send_miss(8'h45, va);
		wait_done(d);
		check_value("read count", 64'(req_log.size()), 64'd1);
		check_value("rd_req.tadr level 0", 64'(req_log[0]), 64'(l0_adr(TABLE_BASE, va)));
		check_done(d, 8'h45, va, 1'b0, walk_ppn(TABLE_BASE, 1'b0, va));
		apb_access(1'b1, 4'h4, 32'h1, r);
	endtask

	task automatic test_full_queue();
		vaddr_t vas[QUEUE_DEPTH];
		logic seen[QUEUE_DEPTH];
		logic [31:0] rng;
		done_t d;
		done_t held;
		int hit;
		int n;
		rng = SEED;
		mem_hold = 1'b1;
		// consecutive xorshift outputs never repeat, so the addresses differ
		for (int i = 0; i < QUEUE_DEPTH; i++) begin
			rng = xorshift32(rng);
			vas[i] = rng;
			seen[i] = 1'b0;
			send_miss(8'h50, vas[i]);
		end
		rng = xorshift32(rng);
		miss.vaddr = rng;
		@(negedge clk);
		check_value("miss_ready", 64'(miss_ready), 64'h0);
		next_cycle();
		done_ready = 1'b0;
		mem_hold = 1'b0;
		n = 0;
		@(negedge clk);
		while (!done_valid) begin
			n++;
			if (n > TIMEOUT)
				stop_with_failure("timeout waiting for the first stalled completion");
			@(negedge clk);
		end
		held = done;
		repeat (6) begin
			@(negedge clk);
			check_value("done_valid", 64'(done_valid), 64'h1);
			check_value("done", 64'(done), 64'(held));
		end
		next_cycle();
		done_ready = 1'b1;
		for (int k = 0; k < QUEUE_DEPTH; k++) begin
			wait_done(d);
			hit = -1;
			for (int i = 0; i < QUEUE_DEPTH; i++)
				if (!seen[i] && d.vaddr == vas[i])
					hit = i;
			if (hit < 0)
				stop_with_failure("completion for an unknown or repeated address");
			else begin
				seen[hit] = 1'b1;
				check_done(d, 8'h50, vas[hit], 1'b0, walk_ppn(TABLE_BASE, 1'b1, vas[hit]));
			end
		end
		expect_quiet(20);
	endtask

	initial begin
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		miss_valid = 1'b0;
		miss = '0;
		done_ready = 1'b1;
		mem_hold = 1'b0;
		fault_en = 1'b0;
		fault_adr = '0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		test_apb_regs();
		test_two_level_walk();
		test_duplicate_miss();
		test_fault_and_short_walk();
		test_full_queue();
		if (dut_i.walk_checks_i.error_count != 0)
			stop_with_failure("bound assertions reported a protocol violation");
		else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== ptw_walk.f ====
design/ptw_cfg_pkg.sv
design/ptw_queue_pkg.sv
design/ptw_stage_reg.sv
design/ptw_apb_regs.sv
design/ptw_miss_queue.sv
design/ptw_read_issue.sv
design/ptw_pte_update.sv
design/ptw_walk.sv
bench/ptw_walk_assertions.sv
bench/tb_ptw_walk.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_ptw_walk

$(SIM): ptw_walk.f $(wildcard design/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ptw_walk -f ptw_walk.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

.PHONY: run clean
